// File: common/audio_ctrl_pkg.sv
// audio control package
// widths, payload types, key indices and pitch presets for the panel controller
`default_nettype none

package audio_ctrl_pkg;

    // audio sample
    localparam int SAMPLE_W = 16;
    typedef logic [SAMPLE_W-1:0] sample_t;

    // pitch word for the voice-change engine
    localparam int FREQ_W = 10;
    typedef logic [FREQ_W-1:0] freq_t;

    // one bit per front-panel key
    localparam int KEY_N = 7;
    typedef logic [KEY_N-1:0] key_vec_t;

    // one-hot codebook select, recognition class
    typedef logic [3:0] lbg_sel_t;
    typedef logic [3:0] vq_class_t;

    // voice-change key map
    localparam int KEY_MODE      = 0;
    localparam int KEY_MALE      = 1;
    localparam int KEY_FEMALE    = 2;
    localparam int KEY_CHILD     = 3;
    localparam int KEY_DEEP      = 4;
    localparam int KEY_SET_UP    = 5;
    localparam int KEY_ORIG_DOWN = 6;

    // recognition key map, same physical keys
    localparam int VQ_KEY_START = 0;
    localparam int VQ_KEY_STOP  = 1;
    localparam int VQ_KEY_TRAIN = 2;
    localparam int VQ_KEY_IDENT = 3;
    localparam int VQ_KEY_LBG2  = 4;
    localparam int VQ_KEY_LBG3  = 5;
    localparam int VQ_KEY_LBG4  = 6;

    // pitch presets
    localparam freq_t F_RESET = 10'd160;
    localparam freq_t F_LOW   = 10'd160;
    localparam freq_t F_MID   = 10'd240;
    localparam freq_t F_HIGH  = 10'd400;
    localparam freq_t F_DEEP  = 10'd90;
    localparam freq_t F_STEP  = 10'd10;

endpackage

`default_nettype wire

// File: common/vq_cmd_if.sv
// recognition command bundle
// panel side drives the strobes and codebook select, engine side reads them
`timescale 1ns/100ps
`default_nettype none

interface vq_cmd_if;

    // one-cycle command strobes
    logic start;
    logic stop;
    logic train_start;
    logic identify_start;
    // held codebook select, one-hot
    audio_ctrl_pkg::lbg_sel_t lbg_sel;

    modport panel (
        output start, stop, train_start, identify_start, lbg_sel
    );

    modport engine (
        input start, stop, train_start, identify_start, lbg_sel
    );

endinterface

`default_nettype wire

// File: logic/key_pulse.sv
// key debouncer
// synchronizes seven keys, filters bounce and pulses once per press
`timescale 1ns/100ps
`default_nettype none

module key_pulse #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                     hdmi_tx_pix_clk,
    input  logic                     key_rstn,
    input  audio_ctrl_pkg::key_vec_t keys,
    output audio_ctrl_pkg::key_vec_t key_evt
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    audio_ctrl_pkg::key_vec_t key_meta;
    audio_ctrl_pkg::key_vec_t key_sync;
    // filtered key level
    audio_ctrl_pkg::key_vec_t key_level;
    logic [CNT_W-1:0] stable_cnt [audio_ctrl_pkg::KEY_N];

    // two-flop synchronizer, keys are asynchronous to the pixel clock
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            key_meta <= '0;
            key_sync <= '0;
        end else begin
            key_meta <= keys;
            key_sync <= key_meta;
        end
    end

    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            key_level <= '0;
            key_evt   <= '0;
            for (int k = 0; k < audio_ctrl_pkg::KEY_N; k++) begin
                stable_cnt[k] <= '0;
            end
        end else begin
            for (int k = 0; k < audio_ctrl_pkg::KEY_N; k++) begin
                key_evt[k] <= 1'b0;
                if (key_sync[k] == key_level[k]) begin
                    // no change pending, restart the window
                    stable_cnt[k] <= '0;
                end else if (stable_cnt[k] == CNT_LAST) begin
                    stable_cnt[k] <= '0;
                    key_level[k]  <= key_sync[k];
                    // rising edge of the filtered level, release is silent
                    key_evt[k]    <= key_sync[k] & ~key_level[k];
                end else begin
                    stable_cnt[k] <= stable_cnt[k] + 1'b1;
                end
            end
        end
    end

    // a press never yields a pulse wider than one cycle
    a_evt_single: assert property (
        @(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        (key_evt & $past(key_evt)) == '0
    );

endmodule

`default_nettype wire

// File: logic/codec_power_up.sv
// codec power-up delay
// keeps the codecs in reset until the PLL has stayed locked long enough
`timescale 1ns/100ps
`default_nettype none

module codec_power_up #(
    parameter int POWER_UP_CYCLES = 327680
) (
    input  logic hdmi_tx_pix_clk,
    input  logic key_rstn,
    input  logic pll_locked,
    output logic codec_rstn
);

    localparam int CNT_W = $clog2(POWER_UP_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(POWER_UP_CYCLES);

    logic [CNT_W-1:0] lock_cnt;

    // saturating lock counter, restarts on any loss of lock
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            lock_cnt <= '0;
        end else if (!pll_locked) begin
            lock_cnt <= '0;
        end else if (lock_cnt != CNT_DONE) begin
            lock_cnt <= lock_cnt + 1'b1;
        end
    end

    // registered release, drops right after lock is lost
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            codec_rstn <= 1'b0;
        end else begin
            codec_rstn <= pll_locked && (lock_cnt == CNT_DONE);
        end
    end

endmodule

`default_nettype wire

// File: logic/voice_preset.sv
// voice-change presets
// mode toggle plus the pitch words handed to the voice-change engine
`timescale 1ns/100ps
`default_nettype none

module voice_preset (
    input  logic                     hdmi_tx_pix_clk,
    input  logic                     key_rstn,
    input  audio_ctrl_pkg::key_vec_t key_evt,
    output logic                     change_en,
    output audio_ctrl_pkg::freq_t    f_set,
    output audio_ctrl_pkg::freq_t    f_original
);

    // mode key flips voice change on and off
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            change_en <= 1'b0;
        end else if (key_evt[audio_ctrl_pkg::KEY_MODE]) begin
            change_en <= ~change_en;
        end
    end

    // presets only while voice change is on
    // later checks override earlier ones so the higher key wins
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            f_set      <= audio_ctrl_pkg::F_RESET;
            f_original <= audio_ctrl_pkg::F_RESET;
        end else if (change_en) begin
            // male voice
            if (key_evt[audio_ctrl_pkg::KEY_MALE]) begin
                f_set      <= audio_ctrl_pkg::F_LOW;
                f_original <= audio_ctrl_pkg::F_MID;
            end
            // female voice
            if (key_evt[audio_ctrl_pkg::KEY_FEMALE]) begin
                f_set      <= audio_ctrl_pkg::F_MID;
                f_original <= audio_ctrl_pkg::F_LOW;
            end
            // child voice
            if (key_evt[audio_ctrl_pkg::KEY_CHILD]) begin
                f_set      <= audio_ctrl_pkg::F_HIGH;
                f_original <= audio_ctrl_pkg::F_LOW;
            end
            // deep voice
            if (key_evt[audio_ctrl_pkg::KEY_DEEP]) begin
                f_set      <= audio_ctrl_pkg::F_DEEP;
                f_original <= audio_ctrl_pkg::F_MID;
            end
            // fine steps, 10-bit wrap is intended
            if (key_evt[audio_ctrl_pkg::KEY_SET_UP]) begin
                f_set <= f_set + audio_ctrl_pkg::F_STEP;
            end
            if (key_evt[audio_ctrl_pkg::KEY_ORIG_DOWN]) begin
                f_original <= f_original - audio_ctrl_pkg::F_STEP;
            end
        end
    end

endmodule

`default_nettype wire

// File: vq_panel/vq_panel.sv
// speaker recognition panel
// command strobes, codebook select and busy/result LEDs for the MFCC/VQ engine
`timescale 1ns/100ps
`default_nettype none

module vq_panel (
    input  logic                      hdmi_tx_pix_clk,
    input  logic                      key_rstn,
    input  audio_ctrl_pkg::key_vec_t  key_evt,
    input  logic                      train_done,
    input  logic                      ident_done,
    input  audio_ctrl_pkg::vq_class_t vq_result,
    vq_cmd_if.panel                   cmd,
    output logic [5:0]                led
);

    logic                      train_busy;
    logic                      ident_busy;
    // last result from the engine
    audio_ctrl_pkg::vq_class_t result_q;

    // command strobes, one cycle behind the key pulse
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            cmd.start          <= 1'b0;
            cmd.stop           <= 1'b0;
            cmd.train_start    <= 1'b0;
            cmd.identify_start <= 1'b0;
        end else begin
            cmd.start          <= key_evt[audio_ctrl_pkg::VQ_KEY_START];
            cmd.stop           <= key_evt[audio_ctrl_pkg::VQ_KEY_STOP];
            cmd.train_start    <= key_evt[audio_ctrl_pkg::VQ_KEY_TRAIN];
            cmd.identify_start <= key_evt[audio_ctrl_pkg::VQ_KEY_IDENT];
        end
    end

    // codebook select, first codebook after reset
    // higher key wins on a tie
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            cmd.lbg_sel <= 4'b0001;
        end else begin
            if (key_evt[audio_ctrl_pkg::VQ_KEY_LBG2]) begin
                cmd.lbg_sel <= 4'b0010;
            end
            if (key_evt[audio_ctrl_pkg::VQ_KEY_LBG3]) begin
                cmd.lbg_sel <= 4'b0100;
            end
            if (key_evt[audio_ctrl_pkg::VQ_KEY_LBG4]) begin
                cmd.lbg_sel <= 4'b1000;
            end
        end
    end

    // training busy
    // done strobe has priority over a new start
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            train_busy <= 1'b0;
        end else if (train_done) begin
            train_busy <= 1'b0;
        end else if (cmd.train_start) begin
            train_busy <= 1'b1;
        end
    end

    // identify busy, same scheme
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            ident_busy <= 1'b0;
        end else if (ident_done) begin
            ident_busy <= 1'b0;
        end else if (cmd.identify_start) begin
            ident_busy <= 1'b1;
        end
    end

    // result sampled on the done strobe, held until the next one
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            result_q <= '0;
        end else if (ident_done) begin
            result_q <= vq_result;
        end
    end

    // led 0 train, led 1 identify, leds 5..2 class
    assign led = {result_q, ident_busy, train_busy};

    // engine relies on exactly one codebook being selected
    a_lbg_onehot: assert property (
        @(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        $onehot(cmd.lbg_sel)
    );

endmodule

`default_nettype wire

// File: logic/sample_route.sv
// DAC sample routing
// picks raw or voice-changed audio and loads the left/right DAC words
`timescale 1ns/100ps
`default_nettype none

module sample_route (
    input  logic                    hdmi_tx_pix_clk,
    input  logic                    key_rstn,
    input  logic                    adc_init_done,
    input  logic                    dac_init_done,
    input  logic                    change_en,
    input  audio_ctrl_pkg::sample_t rx_sample,
    input  logic                    rx_l_vld,
    input  logic                    rx_r_vld,
    input  audio_ctrl_pkg::sample_t voice_sample,
    output audio_ctrl_pkg::sample_t ldata,
    output audio_ctrl_pkg::sample_t rdata
);

    audio_ctrl_pkg::sample_t sample_sel;
    logic                    codecs_ready;

    // processed voice while change mode is on
    assign sample_sel   = change_en ? voice_sample : rx_sample;
    assign codecs_ready = adc_init_done & dac_init_done;

    // mute until both codecs are configured
    always_ff @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            ldata <= '0;
            rdata <= '0;
        end else if (!codecs_ready) begin
            ldata <= '0;
            rdata <= '0;
        end else begin
            if (rx_l_vld) begin
                ldata <= sample_sel;
            end
            if (rx_r_vld) begin
                rdata <= sample_sel;
            end
        end
    end

    // receiver alternates channels, so both strobes never coincide
    a_vld_exclusive: assert property (
        @(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        !(rx_l_vld && rx_r_vld)
    );

endmodule

`default_nettype wire

// File: logic/audio_ctrl_top.sv
// front-panel and audio routing controller
// keys, codec power-up, voice presets, recognition panel and DAC routing
`timescale 1ns/100ps
`default_nettype none

module audio_ctrl_top #(
    parameter int DEBOUNCE_CYCLES = 500000,
    parameter int POWER_UP_CYCLES = 327680
) (
    input  logic                      hdmi_tx_pix_clk,
    input  logic                      key_rstn,
    input  audio_ctrl_pkg::key_vec_t  key_on,
    input  logic                      pll_locked,
    input  logic                      adc_init_done,
    input  logic                      dac_init_done,
    input  audio_ctrl_pkg::sample_t   rx_sample,
    input  logic                      rx_l_vld,
    input  logic                      rx_r_vld,
    input  audio_ctrl_pkg::sample_t   voice_sample,
    input  logic                      train_done,
    input  logic                      ident_done,
    input  audio_ctrl_pkg::vq_class_t vq_result,
    output logic                      codec_rstn,
    output logic                      change_en,
    output audio_ctrl_pkg::freq_t     f_set,
    output audio_ctrl_pkg::freq_t     f_original,
    output audio_ctrl_pkg::sample_t   ldata,
    output audio_ctrl_pkg::sample_t   rdata,
    output logic                      vq_start,
    output logic                      vq_stop,
    output logic                      vq_train_start,
    output logic                      vq_identify_start,
    output audio_ctrl_pkg::lbg_sel_t  vq_lbg_sel,
    output logic [5:0]                led
);

    // debounced key pulses, shared by both panels
    audio_ctrl_pkg::key_vec_t key_evt;

    vq_cmd_if u_vq_cmd ();

    key_pulse #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_key_pulse (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .key_rstn        (key_rstn),
        .keys            (key_on),
        .key_evt         (key_evt)
    );

    codec_power_up #(
        .POWER_UP_CYCLES (POWER_UP_CYCLES)
    ) u_codec_power_up (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .key_rstn        (key_rstn),
        .pll_locked      (pll_locked),
        .codec_rstn      (codec_rstn)
    );

    voice_preset u_voice_preset (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .key_rstn        (key_rstn),
        .key_evt         (key_evt),
        .change_en       (change_en),
        .f_set           (f_set),
        .f_original      (f_original)
    );

    vq_panel u_vq_panel (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .key_rstn        (key_rstn),
        .key_evt         (key_evt),
        .train_done      (train_done),
        .ident_done      (ident_done),
        .vq_result       (vq_result),
        .cmd             (u_vq_cmd.panel),
        .led             (led)
    );

    sample_route u_sample_route (
        .hdmi_tx_pix_clk (hdmi_tx_pix_clk),
        .key_rstn        (key_rstn),
        .adc_init_done   (adc_init_done),
        .dac_init_done   (dac_init_done),
        .change_en       (change_en),
        .rx_sample       (rx_sample),
        .rx_l_vld        (rx_l_vld),
        .rx_r_vld        (rx_r_vld),
        .voice_sample    (voice_sample),
        .ldata           (ldata),
        .rdata           (rdata)
    );

    // recognition commands out to the external engine
    assign vq_start          = u_vq_cmd.start;
    assign vq_stop           = u_vq_cmd.stop;
    assign vq_train_start    = u_vq_cmd.train_start;
    assign vq_identify_start = u_vq_cmd.identify_start;
    assign vq_lbg_sel        = u_vq_cmd.lbg_sel;

endmodule

`default_nettype wire

// File: test/tb_audio_ctrl.sv
// testbench for the front-panel and audio routing controller
// drives keys, PLL lock, samples and engine strobes; assertions compare against a model
`timescale 1ns/100ps
`default_nettype none

module tb_audio_ctrl;

    localparam int POWER_UP = 50;

    logic hdmi_tx_pix_clk = 1'b0;
    logic key_rstn;
    audio_ctrl_pkg::key_vec_t  key_on;
    logic pll_locked, adc_init_done, dac_init_done;
    audio_ctrl_pkg::sample_t   rx_sample, voice_sample, ldata, rdata;
    logic rx_l_vld, rx_r_vld, train_done, ident_done;
    audio_ctrl_pkg::vq_class_t vq_result;
    logic codec_rstn, change_en;
    audio_ctrl_pkg::freq_t     f_set, f_original;
    logic vq_start, vq_stop, vq_train_start, vq_identify_start;
    audio_ctrl_pkg::lbg_sel_t  vq_lbg_sel;
    logic [5:0] led;

    // reference model state
    logic        exp_change_en;
    logic [9:0]  exp_f_set, exp_f_orig;
    logic [3:0]  exp_lbg;
    logic [3:0][7:0] exp_cnt, pulse_cnt;
    logic [3:0]  cmd_vec, exp_result;
    logic        check_now, ready_q, l_load_q, r_load_q;
    audio_ctrl_pkg::sample_t sel_q;
    integer      seed = 32'h9f31;

    audio_ctrl_top #(
        .DEBOUNCE_CYCLES (4),
        .POWER_UP_CYCLES (POWER_UP)
    ) u_audio_ctrl_top (.*);

    always #10 hdmi_tx_pix_clk = ~hdmi_tx_pix_clk;

    assign cmd_vec = {vq_identify_start, vq_train_start, vq_stop, vq_start};

    // strobe counters and routing expectations, one cycle behind the inputs
    always @(posedge hdmi_tx_pix_clk or negedge key_rstn) begin
        if (!key_rstn) begin
            pulse_cnt  <= '0;
            exp_result <= '0;
            ready_q    <= 1'b0;
            l_load_q   <= 1'b0;
            r_load_q   <= 1'b0;
            sel_q      <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                pulse_cnt[i] <= pulse_cnt[i] + 8'(cmd_vec[i]);
            end
            if (ident_done) begin
                exp_result <= vq_result;
            end
            ready_q  <= adc_init_done & dac_init_done;
            l_load_q <= rx_l_vld & adc_init_done & dac_init_done;
            r_load_q <= rx_r_vld & adc_init_done & dac_init_done;
            sel_q    <= exp_change_en ? voice_sample : rx_sample;
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // codec reset release and drop
    a_codec_rise: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        $rose(pll_locked) ##1 pll_locked[*POWER_UP] |-> ##1 $rose(codec_rstn))
        else report_error($sformatf("Fail %0t codec_rstn expected 1 got %b",
            $time, $sampled(codec_rstn)));
    a_codec_fall: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        !pll_locked |=> !codec_rstn)
        else report_error($sformatf("Fail %0t codec_rstn expected 0 got 1", $time));

    // command strobes are single-cycle and one per press
    a_cmd_width: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        (cmd_vec & $past(cmd_vec)) == 4'b0)
        else report_error("a vq command strobe stayed high for two cycles");
    a_cmd_count: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        check_now |-> pulse_cnt == exp_cnt)
        else report_error($sformatf("Fail %0t vq pulse counts expected %h got %h",
            $time, $sampled(exp_cnt), $sampled(pulse_cnt)));
    a_lbg: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        check_now |-> vq_lbg_sel == exp_lbg)
        else report_error($sformatf("Fail %0t vq_lbg_sel expected %b got %b",
            $time, $sampled(exp_lbg), $sampled(vq_lbg_sel)));

    // voice-change mode and presets
    a_mode: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        check_now |-> change_en == exp_change_en)
        else report_error($sformatf("Fail %0t change_en expected %b got %b",
            $time, $sampled(exp_change_en), $sampled(change_en)));
    a_f_set: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        check_now |-> f_set == exp_f_set)
        else report_error($sformatf("Fail %0t f_set expected %0d got %0d",
            $time, $sampled(exp_f_set), $sampled(f_set)));
    a_f_orig: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        check_now |-> f_original == exp_f_orig)
        else report_error($sformatf("Fail %0t f_original expected %0d got %0d",
            $time, $sampled(exp_f_orig), $sampled(f_original)));

    // DAC words
    a_mute: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        !ready_q |-> ldata == '0 && rdata == '0)
        else report_error($sformatf("Fail %0t ldata/rdata expected 0 got %h/%h",
            $time, $sampled(ldata), $sampled(rdata)));
    a_ldata: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        l_load_q |-> ldata == sel_q)
        else report_error($sformatf("Fail %0t ldata expected %h got %h",
            $time, $sampled(sel_q), $sampled(ldata)));
    a_rdata: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        r_load_q |-> rdata == sel_q)
        else report_error($sformatf("Fail %0t rdata expected %h got %h",
            $time, $sampled(sel_q), $sampled(rdata)));

    // busy and result LEDs
    a_train_set: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        vq_train_start && !train_done |=> led[0])
        else report_error($sformatf("Fail %0t led[0] expected 1 got 0", $time));
    a_train_clr: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        train_done |=> !led[0])
        else report_error($sformatf("Fail %0t led[0] expected 0 got 1", $time));
    a_ident_set: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        vq_identify_start && !ident_done |=> led[1])
        else report_error($sformatf("Fail %0t led[1] expected 1 got 0", $time));
    a_ident_clr: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        ident_done |=> !led[1])
        else report_error($sformatf("Fail %0t led[1] expected 0 got 1", $time));
    a_result: assert property (@(posedge hdmi_tx_pix_clk) disable iff (!key_rstn)
        led[5:2] == exp_result)
        else report_error($sformatf("Fail %0t led[5:2] expected %h got %h",
            $time, $sampled(exp_result), $sampled(led[5:2])));

    // model of one key press, applied once the press is over
    task automatic apply_key(input int k);
        if (k < 4) begin
            exp_cnt[k] = exp_cnt[k] + 8'd1;
        end else begin
            exp_lbg = 4'b0001 << (k - 3);
        end
        if (k == 0) begin
            exp_change_en = ~exp_change_en;
        end else if (exp_change_en) begin
            case (k)
                1: begin
                    exp_f_set  = 10'd160;
                    exp_f_orig = 10'd240;
                end
                2: begin
                    exp_f_set  = 10'd240;
                    exp_f_orig = 10'd160;
                end
                3: begin
                    exp_f_set  = 10'd400;
                    exp_f_orig = 10'd160;
                end
                4: begin
                    exp_f_set  = 10'd90;
                    exp_f_orig = 10'd240;
                end
                5: exp_f_set  = exp_f_set + 10'd10;
                6: exp_f_orig = exp_f_orig - 10'd10;
                default: ;
            endcase
        end
    endtask

    // hold 12 cycles, release 12, then one check cycle
    task automatic press_key(input int k);
        key_on[k] = 1'b1;
        repeat (12) @(negedge hdmi_tx_pix_clk);
        key_on[k] = 1'b0;
        repeat (12) @(negedge hdmi_tx_pix_clk);
        apply_key(k);
        check_now = 1'b1;
        @(negedge hdmi_tx_pix_clk);
        check_now = 1'b0;
    endtask

    task automatic wait_codec(input logic level, input int limit);
        int n;
        n = 0;
        while (codec_rstn !== level && n < limit) begin
            @(negedge hdmi_tx_pix_clk);
            n++;
        end
        if (codec_rstn !== level) report_error("codec_rstn did not change in time");
    endtask

    task automatic wait_led(input int idx, input logic level, input int limit);
        int n;
        n = 0;
        while (led[idx] !== level && n < limit) begin
            @(negedge hdmi_tx_pix_clk);
            n++;
        end
        if (led[idx] !== level) report_error("a busy LED did not change in time");
    endtask

    // alternating left/right strobes with random audio
    task automatic send_samples(input int n);
        for (int i = 0; i < n; i++) begin
            rx_sample    = audio_ctrl_pkg::sample_t'($random(seed));
            voice_sample = audio_ctrl_pkg::sample_t'($random(seed));
            rx_l_vld     = (i % 2 == 0);
            rx_r_vld     = (i % 2 != 0);
            @(negedge hdmi_tx_pix_clk);
        end
        rx_l_vld = 1'b0;
        rx_r_vld = 1'b0;
        @(negedge hdmi_tx_pix_clk);
    endtask

    task automatic strobe_done(input logic is_ident);
        if (is_ident) ident_done = 1'b1;
        else train_done = 1'b1;
        @(negedge hdmi_tx_pix_clk);
        ident_done = 1'b0;
        train_done = 1'b0;
    endtask

    initial begin
        key_rstn = 1'b0;
        key_on = '0;
        {pll_locked, adc_init_done, dac_init_done} = 3'b000;
        {rx_l_vld, rx_r_vld, train_done, ident_done} = 4'b0000;
        rx_sample = '0;
        voice_sample = '0;
        vq_result = '0;
        {check_now, exp_change_en} = 2'b00;
        exp_f_set = 10'd160;
        exp_f_orig = 10'd160;
        exp_lbg = 4'b0001;
        exp_cnt = '0;
        repeat (8) @(negedge hdmi_tx_pix_clk);
        key_rstn = 1'b1;
        repeat (4) @(negedge hdmi_tx_pix_clk);
        // lock, lose lock, lock again
        pll_locked = 1'b1;
        wait_codec(1'b1, 100);
        repeat (20) @(negedge hdmi_tx_pix_clk);
        pll_locked = 1'b0;
        wait_codec(1'b0, 5);
        repeat (5) @(negedge hdmi_tx_pix_clk);
        pll_locked = 1'b1;
        wait_codec(1'b1, 100);
        // presets ignored with mode off, then every key with mode on
        for (int k = 1; k < 7; k++) press_key(k);
        press_key(0);
        for (int k = 1; k < 7; k++) press_key(k);
        press_key(5);
        press_key(6);
        // routing before and after codec init, processed voice selected
        send_samples(6);
        adc_init_done = 1'b1;
        send_samples(4);
        dac_init_done = 1'b1;
        send_samples(16);
        press_key(0);
        send_samples(16);
        // training busy LED
        strobe_done(1'b0);
        wait_led(0, 1'b0, 5);
        press_key(2);
        wait_led(0, 1'b1, 5);
        strobe_done(1'b0);
        wait_led(0, 1'b0, 5);
        // identify busy LED and result latch
        // nonzero class so a latch that never loads shows up
        press_key(3);
        wait_led(1, 1'b1, 5);
        vq_result = audio_ctrl_pkg::vq_class_t'($random(seed)) | 4'b0001;
        strobe_done(1'b1);
        wait_led(1, 1'b0, 5);
        vq_result = ~vq_result;
        repeat (5) @(negedge hdmi_tx_pix_clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
common/audio_ctrl_pkg.sv
common/vq_cmd_if.sv
logic/key_pulse.sv
logic/codec_power_up.sv
logic/voice_preset.sv
vq_panel/vq_panel.sv
logic/sample_route.sv
logic/audio_ctrl_top.sv
test/tb_audio_ctrl.sv
